// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

	// ----------------------------------------
	// Bus geometry
	// ----------------------------------------
	// AXI4-Lite data bus, fixed at one 32-bit word
	localparam int DATA_WIDTH = 32;
	// Byte address covering sixteen words
	localparam int ADDR_WIDTH = 6;
	// Byte offset bits inside a word
	localparam int ADDR_LSB = 2;
	// One strobe per byte lane
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	// Word index left above the byte offset
	localparam int INDEX_WIDTH = ADDR_WIDTH - ADDR_LSB;
	// Kernel size, stride and padding
	localparam int PARAM_WIDTH = 8;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;
	typedef logic [INDEX_WIDTH-1:0] reg_index_t;
	typedef logic [PARAM_WIDTH-1:0] param8_t;

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	localparam reg_index_t REG_CTRL = reg_index_t'(0);
	localparam reg_index_t REG_KERNEL_BASE = reg_index_t'(1);
	localparam reg_index_t REG_FEATURE_BASE = reg_index_t'(2);
	localparam reg_index_t REG_FEATURE_WIDTH = reg_index_t'(3);
	localparam reg_index_t REG_FEATURE_HEIGHT = reg_index_t'(4);
	localparam reg_index_t REG_FEATURE_CHIN = reg_index_t'(5);
	localparam reg_index_t REG_FEATURE_CHOUT = reg_index_t'(6);
	localparam reg_index_t REG_OUTPUT_BASE = reg_index_t'(7);
	localparam reg_index_t REG_OUTPUT_WIDTH = reg_index_t'(8);
	localparam reg_index_t REG_OUTPUT_HEIGHT = reg_index_t'(9);

	// Control word layout, bit 4 reads as zero
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_EXCEPTION_BIT = 1;
	localparam int CTRL_DONE_BIT = 2;
	localparam int CTRL_RUNNING_BIT = 3;
	localparam int CTRL_MODE_BIT = 5;
	localparam int CTRL_RELU_BIT = 6;
	localparam int CTRL_BIAS_BIT = 7;
	localparam int CTRL_PADDING_LSB = 8;
	localparam int CTRL_STRIDE_LSB = 16;
	localparam int CTRL_KERNEL_LSB = 24;

	// ----------------------------------------
	// Channel state machines
	// ----------------------------------------
	typedef enum logic [1:0] {WR_IDLE, WR_WAIT_ADDR, WR_WAIT_DATA} write_state_e;
	typedef enum logic [1:0] {RD_IDLE, RD_WAIT_ADDR, RD_SEND_DATA} read_state_e;

	// One accepted register write
	typedef struct packed {
		reg_index_t index;
		data_t data;
		strb_t strb;
	} csr_write_t;

	// Full accelerator configuration
	typedef struct packed {
		param8_t kernel_size;
		param8_t stride;
		param8_t padding;
		logic has_bias;
		logic has_relu;
		logic conv_mode;
		data_t kernel_baseaddr;
		data_t feature_baseaddr;
		data_t feature_width;
		data_t feature_height;
		data_t feature_chin;
		data_t feature_chout;
		data_t output_baseaddr;
		data_t output_width;
		data_t output_height;
	} conv_config_t;

	// Live status from the compute core
	typedef struct packed {
		logic running;
		logic compute_done;
		logic exception;
	} accel_status_t;

endpackage

`default_nettype wire

// File: verilog/csr_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module csr_write_channel (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write address channel
	input wire csr_pkg::addr_t S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	// Write data channel
	input wire csr_pkg::data_t S_AXI_WDATA,
	input wire csr_pkg::strb_t S_AXI_WSTRB,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// Write response channel
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	// Command to the register bank
	output logic wr_valid,
	output csr_pkg::csr_write_t wr_cmd
);

	csr_pkg::write_state_e state;
	csr_pkg::reg_index_t wr_index;
	logic aw_fire;
	logic b_fire;

	assign aw_fire = S_AXI_AWVALID && S_AXI_AWREADY;
	assign b_fire = S_AXI_BVALID && S_AXI_BREADY;

	// ----------------------------------------
	// Handshake state machine
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= csr_pkg::WR_IDLE;
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			S_AXI_BVALID <= 1'b0;
		end
		else
		begin
			// Response drops once the master takes it
			if (b_fire)
				S_AXI_BVALID <= 1'b0;
			case (state)
				csr_pkg::WR_IDLE:
				begin
					// First cycle out of reset, open the address channel
					S_AXI_AWREADY <= 1'b1;
					state <= csr_pkg::WR_WAIT_ADDR;
				end
				csr_pkg::WR_WAIT_ADDR:
				begin
					// Address taken, switch over to the data beat
					if (aw_fire)
					begin
						S_AXI_AWREADY <= 1'b0;
						S_AXI_WREADY <= 1'b1;
						state <= csr_pkg::WR_WAIT_DATA;
					end
				end
				csr_pkg::WR_WAIT_DATA:
				begin
					if (wr_valid)
					begin
						S_AXI_WREADY <= 1'b0;
						// Overrides the drop above, response always OKAY
						S_AXI_BVALID <= 1'b1;
						S_AXI_AWREADY <= 1'b1;
						state <= csr_pkg::WR_WAIT_ADDR;
					end
				end
				default:
					state <= csr_pkg::WR_IDLE;
			endcase
		end
	end

	// Word index of the pending write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_fire)
			wr_index <= S_AXI_AWADDR[csr_pkg::ADDR_WIDTH-1:csr_pkg::ADDR_LSB];
	end

	// Bank commits on the W handshake edge itself
	assign wr_valid = S_AXI_WVALID && S_AXI_WREADY;
	assign wr_cmd = '{index: wr_index, data: S_AXI_WDATA, strb: S_AXI_WSTRB};

	// Master may stall B for as long as it likes
	bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

endmodule

`default_nettype wire

// File: verilog/csr_register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module csr_register_bank (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write command from the write channel
	input wire wr_valid,
	input wire csr_pkg::csr_write_t wr_cmd,
	// Configuration and start to the accelerator
	output csr_pkg::conv_config_t conv_config,
	output logic start
);

	// Byte lane merge under the write strobes
	function automatic csr_pkg::data_t merge_bytes(
		input csr_pkg::data_t old_word,
		input csr_pkg::csr_write_t cmd
	);
		csr_pkg::data_t merged;
		merged = old_word;
		for (int b = 0; b < csr_pkg::STRB_WIDTH; b++)
		begin
			if (cmd.strb[b])
				merged[b*8 +: 8] = cmd.data[b*8 +: 8];
		end
		return merged;
	endfunction

	// ----------------------------------------
	// Register update
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			conv_config <= '0;
			start <= 1'b0;
		end
		else
		begin
			// Start lasts one cycle unless rewritten
			start <= 1'b0;
			if (wr_valid)
			begin
				case (wr_cmd.index)
					csr_pkg::REG_CTRL:
					begin
						// Whole word taken, strobes do not apply here
						start <= wr_cmd.data[csr_pkg::CTRL_START_BIT];
						conv_config.conv_mode <= wr_cmd.data[csr_pkg::CTRL_MODE_BIT];
						conv_config.has_relu <= wr_cmd.data[csr_pkg::CTRL_RELU_BIT];
						conv_config.has_bias <= wr_cmd.data[csr_pkg::CTRL_BIAS_BIT];
						conv_config.padding <=
							wr_cmd.data[csr_pkg::CTRL_PADDING_LSB +: csr_pkg::PARAM_WIDTH];
						conv_config.stride <=
							wr_cmd.data[csr_pkg::CTRL_STRIDE_LSB +: csr_pkg::PARAM_WIDTH];
						conv_config.kernel_size <=
							wr_cmd.data[csr_pkg::CTRL_KERNEL_LSB +: csr_pkg::PARAM_WIDTH];
						// Status bits 4..1 are read only
					end
					csr_pkg::REG_KERNEL_BASE:
						conv_config.kernel_baseaddr <=
							merge_bytes(conv_config.kernel_baseaddr, wr_cmd);
					csr_pkg::REG_FEATURE_BASE:
						conv_config.feature_baseaddr <=
							merge_bytes(conv_config.feature_baseaddr, wr_cmd);
					csr_pkg::REG_FEATURE_WIDTH:
						conv_config.feature_width <=
							merge_bytes(conv_config.feature_width, wr_cmd);
					csr_pkg::REG_FEATURE_HEIGHT:
						conv_config.feature_height <=
							merge_bytes(conv_config.feature_height, wr_cmd);
					csr_pkg::REG_FEATURE_CHIN:
						conv_config.feature_chin <=
							merge_bytes(conv_config.feature_chin, wr_cmd);
					csr_pkg::REG_FEATURE_CHOUT:
						conv_config.feature_chout <=
							merge_bytes(conv_config.feature_chout, wr_cmd);
					csr_pkg::REG_OUTPUT_BASE:
						conv_config.output_baseaddr <=
							merge_bytes(conv_config.output_baseaddr, wr_cmd);
					csr_pkg::REG_OUTPUT_WIDTH:
						conv_config.output_width <=
							merge_bytes(conv_config.output_width, wr_cmd);
					csr_pkg::REG_OUTPUT_HEIGHT:
						conv_config.output_height <=
							merge_bytes(conv_config.output_height, wr_cmd);
					default:
					begin
						// Indices 10..15 are unmapped, write is dropped
					end
				endcase
			end
		end
	end

	// Writes are spaced by the AW/W/B sequence, so start never stretches
	start_single: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		start |=> !start);

endmodule

`default_nettype wire

// File: verilog/csr_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_channel (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Read address channel
	input wire csr_pkg::addr_t S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	// Read data channel
	output csr_pkg::data_t S_AXI_RDATA,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// Register state and live status
	input wire csr_pkg::conv_config_t conv_config,
	input wire start,
	input wire csr_pkg::accel_status_t status
);

	csr_pkg::read_state_e state;
	csr_pkg::reg_index_t rd_index;
	csr_pkg::data_t ctrl_word;
	logic ar_fire;
	logic r_fire;

	assign ar_fire = S_AXI_ARVALID && S_AXI_ARREADY;
	assign r_fire = S_AXI_RVALID && S_AXI_RREADY;

	// ----------------------------------------
	// Handshake state machine
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= csr_pkg::RD_IDLE;
			S_AXI_ARREADY <= 1'b0;
			S_AXI_RVALID <= 1'b0;
			rd_index <= '0;
		end
		else
		begin
			case (state)
				csr_pkg::RD_IDLE:
				begin
					S_AXI_ARREADY <= 1'b1;
					state <= csr_pkg::RD_WAIT_ADDR;
				end
				csr_pkg::RD_WAIT_ADDR:
				begin
					// Latch the word index, data follows next cycle
					if (ar_fire)
					begin
						rd_index <= S_AXI_ARADDR[csr_pkg::ADDR_WIDTH-1:csr_pkg::ADDR_LSB];
						S_AXI_ARREADY <= 1'b0;
						S_AXI_RVALID <= 1'b1;
						state <= csr_pkg::RD_SEND_DATA;
					end
				end
				csr_pkg::RD_SEND_DATA:
				begin
					if (r_fire)
					begin
						S_AXI_RVALID <= 1'b0;
						S_AXI_ARREADY <= 1'b1;
						state <= csr_pkg::RD_WAIT_ADDR;
					end
				end
				default:
					state <= csr_pkg::RD_IDLE;
			endcase
		end
	end

	// Control word, status bits sampled live
	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[csr_pkg::CTRL_START_BIT] = start;
		ctrl_word[csr_pkg::CTRL_EXCEPTION_BIT] = status.exception;
		ctrl_word[csr_pkg::CTRL_DONE_BIT] = status.compute_done;
		ctrl_word[csr_pkg::CTRL_RUNNING_BIT] = status.running;
		ctrl_word[csr_pkg::CTRL_MODE_BIT] = conv_config.conv_mode;
		ctrl_word[csr_pkg::CTRL_RELU_BIT] = conv_config.has_relu;
		ctrl_word[csr_pkg::CTRL_BIAS_BIT] = conv_config.has_bias;
		ctrl_word[csr_pkg::CTRL_PADDING_LSB +: csr_pkg::PARAM_WIDTH] = conv_config.padding;
		ctrl_word[csr_pkg::CTRL_STRIDE_LSB +: csr_pkg::PARAM_WIDTH] = conv_config.stride;
		ctrl_word[csr_pkg::CTRL_KERNEL_LSB +: csr_pkg::PARAM_WIDTH] = conv_config.kernel_size;
	end

	// Read mux, unmapped indices return zero
	always_comb
	begin
		case (rd_index)
			csr_pkg::REG_CTRL: S_AXI_RDATA = ctrl_word;
			csr_pkg::REG_KERNEL_BASE: S_AXI_RDATA = conv_config.kernel_baseaddr;
			csr_pkg::REG_FEATURE_BASE: S_AXI_RDATA = conv_config.feature_baseaddr;
			csr_pkg::REG_FEATURE_WIDTH: S_AXI_RDATA = conv_config.feature_width;
			csr_pkg::REG_FEATURE_HEIGHT: S_AXI_RDATA = conv_config.feature_height;
			csr_pkg::REG_FEATURE_CHIN: S_AXI_RDATA = conv_config.feature_chin;
			csr_pkg::REG_FEATURE_CHOUT: S_AXI_RDATA = conv_config.feature_chout;
			csr_pkg::REG_OUTPUT_BASE: S_AXI_RDATA = conv_config.output_baseaddr;
			csr_pkg::REG_OUTPUT_WIDTH: S_AXI_RDATA = conv_config.output_width;
			csr_pkg::REG_OUTPUT_HEIGHT: S_AXI_RDATA = conv_config.output_height;
			default: S_AXI_RDATA = '0;
		endcase
	end

	// Data and its index hold while the master stalls R
	rvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(rd_index));

endmodule

`default_nettype wire

// File: verilog/axi_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_csr_top (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write address, data and response
	input wire csr_pkg::addr_t S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output wire S_AXI_AWREADY,
	input wire csr_pkg::data_t S_AXI_WDATA,
	input wire csr_pkg::strb_t S_AXI_WSTRB,
	input wire S_AXI_WVALID,
	output wire S_AXI_WREADY,
	output wire S_AXI_BVALID,
	input wire S_AXI_BREADY,
	// Read address and data
	input wire csr_pkg::addr_t S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output wire S_AXI_ARREADY,
	output wire csr_pkg::data_t S_AXI_RDATA,
	output wire S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// Accelerator side
	input wire running,
	input wire compute_done,
	input wire exception,
	output wire csr_pkg::conv_config_t conv_config,
	output wire start
);

	wire wr_valid;
	csr_pkg::csr_write_t wr_cmd;
	csr_pkg::accel_status_t status;

	// Status bits gathered for the read mux
	assign status = '{running: running, compute_done: compute_done, exception: exception};

	// ----------------------------------------
	// Write path, then bank, then read path
	// ----------------------------------------
	csr_write_channel u_write (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA (S_AXI_WDATA),
		.S_AXI_WSTRB (S_AXI_WSTRB),
		.S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY),
		.S_AXI_BVALID (S_AXI_BVALID),
		.S_AXI_BREADY (S_AXI_BREADY),
		.wr_valid (wr_valid),
		.wr_cmd (wr_cmd)
	);

	csr_register_bank u_bank (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_valid (wr_valid),
		.wr_cmd (wr_cmd),
		.conv_config (conv_config),
		.start (start)
	);

	csr_read_channel u_read (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_ARADDR (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA (S_AXI_RDATA),
		.S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY),
		.conv_config (conv_config),
		.start (start),
		.status (status)
	);

endmodule

`default_nettype wire

// File: verification/axi_csr_tb_tasks.svh
`ifndef AXI_CSR_TB_TASKS_SVH
`define AXI_CSR_TB_TASKS_SVH

// ----------------------------------------
// Checking and reference model
// ----------------------------------------
task automatic check_value(input string name, input csr_pkg::data_t expected,
	input csr_pkg::data_t actual);
	if (expected !== actual)
	begin
		$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		$display("Checks failed");
		$fatal(1, "Stopped at first mismatch");
	end
endtask

task automatic report_hang(input string channel);
	$display("Timeout at %0t ns: the %s handshake never completed", $time, channel);
	$display("Checks failed");
	$fatal(1, "Bus handshake hung");
endtask

function automatic int rand_below(input int limit);
	return {$random(seed)} % limit;
endfunction

function automatic void model_write(input csr_pkg::reg_index_t index,
	input csr_pkg::data_t data, input csr_pkg::strb_t strb);
	if (index == csr_pkg::REG_CTRL)
	begin
		// Only bits 31..5 are stored since start clears and status is read only
		model_regs[index] = data & 32'hFFFF_FFE0;
	end
	else if (index <= csr_pkg::REG_OUTPUT_HEIGHT)
	begin
		for (int b = 0; b < 4; b++)
		begin
			if (strb[b])
				model_regs[index][b*8 +: 8] = data[b*8 +: 8];
		end
	end
endfunction

function automatic csr_pkg::data_t expected_read(input csr_pkg::reg_index_t index);
	csr_pkg::data_t word;
	word = model_regs[index];
	// Live status in bits 3..1
	if (index == csr_pkg::REG_CTRL)
		word[3:1] = {running, compute_done, exception};
	return word;
endfunction

function automatic csr_pkg::data_t dut_field(input int index);
	case (index)
		1: return conv_config.kernel_baseaddr;
		2: return conv_config.feature_baseaddr;
		3: return conv_config.feature_width;
		4: return conv_config.feature_height;
		5: return conv_config.feature_chin;
		6: return conv_config.feature_chout;
		7: return conv_config.output_baseaddr;
		8: return conv_config.output_width;
		default: return conv_config.output_height;
	endcase
endfunction

task automatic check_config();
	check_value("conv_config.kernel_size", 32'(model_regs[0][31:24]), 32'(conv_config.kernel_size));
	check_value("conv_config.stride", 32'(model_regs[0][23:16]), 32'(conv_config.stride));
	check_value("conv_config.padding", 32'(model_regs[0][15:8]), 32'(conv_config.padding));
	check_value("conv_config.has_bias", 32'(model_regs[0][7]), 32'(conv_config.has_bias));
	check_value("conv_config.has_relu", 32'(model_regs[0][6]), 32'(conv_config.has_relu));
	check_value("conv_config.conv_mode", 32'(model_regs[0][5]), 32'(conv_config.conv_mode));
	for (int i = 1; i < 10; i++)
		check_value($sformatf("conv_config word %0d", i), model_regs[i], dut_field(i));
endtask

task automatic drive_status();
	@(posedge S_AXI_ACLK);
	{running, compute_done, exception} <= 3'($random(seed));
endtask

// ----------------------------------------
// AXI4-Lite master
// ----------------------------------------
task automatic axi_write(input csr_pkg::reg_index_t index, input csr_pkg::data_t data,
	input csr_pkg::strb_t strb);
	int wait_cycles;
	@(posedge S_AXI_ACLK);
	awaddr <= {index, 2'b00};
	awvalid <= 1'b1;
	wait_cycles = 0;
	do
	begin
		@(negedge S_AXI_ACLK);
		wait_cycles++;
		if (wait_cycles > TIMEOUT_CYCLES)
			report_hang("AW");
	end while (!awready);
	// Data beat follows the AW handshake edge
	@(posedge S_AXI_ACLK);
	awvalid <= 1'b0;
	wdata <= data;
	wstrb <= strb;
	wvalid <= 1'b1;
	wait_cycles = 0;
	do
	begin
		@(negedge S_AXI_ACLK);
		wait_cycles++;
		if (wait_cycles > TIMEOUT_CYCLES)
			report_hang("W");
	end while (!wready);
	@(posedge S_AXI_ACLK);
	wvalid <= 1'b0;
	model_write(index, data, strb);
	// Hold off B for a random while
	repeat (rand_below(4)) @(posedge S_AXI_ACLK);
	bready <= 1'b1;
	wait_cycles = 0;
	do
	begin
		@(negedge S_AXI_ACLK);
		wait_cycles++;
		if (wait_cycles > TIMEOUT_CYCLES)
			report_hang("B");
	end while (!bvalid);
	@(posedge S_AXI_ACLK);
	bready <= 1'b0;
	check_config();
endtask

task automatic axi_read(input csr_pkg::reg_index_t index, output csr_pkg::data_t data);
	int wait_cycles;
	@(posedge S_AXI_ACLK);
	araddr <= {index, 2'b00};
	arvalid <= 1'b1;
	wait_cycles = 0;
	do
	begin
		@(negedge S_AXI_ACLK);
		wait_cycles++;
		if (wait_cycles > TIMEOUT_CYCLES)
			report_hang("AR");
	end while (!arready);
	@(posedge S_AXI_ACLK);
	arvalid <= 1'b0;
	// RVALID has to hold through the stall
	repeat (rand_below(4)) @(posedge S_AXI_ACLK);
	rready <= 1'b1;
	wait_cycles = 0;
	do
	begin
		@(negedge S_AXI_ACLK);
		wait_cycles++;
		if (wait_cycles > TIMEOUT_CYCLES)
			report_hang("R");
	end while (!rvalid);
	data = rdata;
	@(posedge S_AXI_ACLK);
	rready <= 1'b0;
endtask

task automatic read_and_compare(input csr_pkg::reg_index_t index);
	csr_pkg::data_t data;
	axi_read(index, data);
	check_value($sformatf("RDATA index %0d", index), expected_read(index), data);
endtask

`endif

// File: verification/axi_csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_csr_tb;

	// Cycles any single handshake may take before the run is abandoned
	localparam int TIMEOUT_CYCLES = 50;
	localparam int ROUNDS = 30;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	// Write channels
	csr_pkg::addr_t awaddr;
	logic awvalid;
	wire awready;
	csr_pkg::data_t wdata;
	csr_pkg::strb_t wstrb;
	logic wvalid;
	wire wready;
	wire bvalid;
	logic bready;
	// Read channels
	csr_pkg::addr_t araddr;
	logic arvalid;
	wire arready;
	wire csr_pkg::data_t rdata;
	wire rvalid;
	logic rready;
	// Accelerator side
	logic running;
	logic compute_done;
	logic exception;
	wire csr_pkg::conv_config_t conv_config;
	wire start;

	// Reference register image where indices 10..15 stay zero
	csr_pkg::data_t model_regs [0:15];
	integer seed = 17;
	logic start_due = 1'b0;
	csr_pkg::reg_index_t idx;

	`include "axi_csr_tb_tasks.svh"

	axi_csr_top UUT (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR (awaddr),
		.S_AXI_AWVALID (awvalid),
		.S_AXI_AWREADY (awready),
		.S_AXI_WDATA (wdata),
		.S_AXI_WSTRB (wstrb),
		.S_AXI_WVALID (wvalid),
		.S_AXI_WREADY (wready),
		.S_AXI_BVALID (bvalid),
		.S_AXI_BREADY (bready),
		.S_AXI_ARADDR (araddr),
		.S_AXI_ARVALID (arvalid),
		.S_AXI_ARREADY (arready),
		.S_AXI_RDATA (rdata),
		.S_AXI_RVALID (rvalid),
		.S_AXI_RREADY (rready),
		.running (running),
		.compute_done (compute_done),
		.exception (exception),
		.conv_config (conv_config),
		.start (start)
	);

	// 40 ns clock
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// ----------------------------------------
	// Start pulse monitor
	// ----------------------------------------
	// Due one cycle after a W beat to the control word with bit 0 set
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
			check_value("start", 32'(start_due), 32'(start));
		start_due = S_AXI_ARESETN && wvalid && wready && wdata[csr_pkg::CTRL_START_BIT]
			&& awaddr[csr_pkg::ADDR_WIDTH-1:csr_pkg::ADDR_LSB] == csr_pkg::REG_CTRL;
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		// Idle bus and quiet status from time zero
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		running = 1'b0;
		compute_done = 1'b0;
		exception = 1'b0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		repeat (3) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;

		// Reset values with only the live status in the control word
		drive_status();
		check_config();
		for (int i = 0; i < 16; i++)
			read_and_compare(csr_pkg::reg_index_t'(i));

		// Full words into the parameter registers
		repeat (ROUNDS)
		begin
			idx = csr_pkg::reg_index_t'(1 + rand_below(9));
			axi_write(idx, $random(seed), 4'hF);
			read_and_compare(idx);
		end
		// Byte merge under random strobes
		repeat (ROUNDS)
		begin
			idx = csr_pkg::reg_index_t'(1 + rand_below(9));
			axi_write(idx, $random(seed), csr_pkg::strb_t'($random(seed)));
			read_and_compare(idx);
		end
		// Control word takes the whole beat whatever the strobes
		repeat (ROUNDS)
		begin
			axi_write(csr_pkg::REG_CTRL, $random(seed), csr_pkg::strb_t'($random(seed)));
			read_and_compare(csr_pkg::REG_CTRL);
		end
		// Status inputs held, then read back
		repeat (10)
		begin
			drive_status();
			read_and_compare(csr_pkg::REG_CTRL);
		end
		// Unmapped indices answer but store nothing
		repeat (10)
		begin
			idx = csr_pkg::reg_index_t'(10 + rand_below(6));
			axi_write(idx, $random(seed), 4'hF);
			read_and_compare(idx);
		end
		for (int i = 1; i < 10; i++)
			read_and_compare(csr_pkg::reg_index_t'(i));

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
verilog/csr_pkg.sv
verilog/csr_write_channel.sv
verilog/csr_register_bank.sv
verilog/csr_read_channel.sv
verilog/axi_csr_top.sv
verification/axi_csr_tb.sv

// File: run.sh
#!/bin/sh
# Build the CSR block and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module axi_csr_tb -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vaxi_csr_tb 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
